//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cpu
RTL_TOP    := cpu_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --assert -j 0
LINT_FLAGS := --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// First fetch address
`define CPU_RESET_PC 32'h0000_0000

// FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK
`define CPU_STAGES 5

// x0 included
`define CPU_NREGS 32

`endif

//--- common/cpu_pkg.sv
package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   typedef enum logic [2:0] {
      FETCH,
      DECODE,
      EXECUTE,
      MEMORY,
      WRITEBACK
   } stage_e;

   typedef enum logic [3:0] {
      RTYPE, ITYPE, STYPE, BTYPE, UTYPE, UPCTYPE, LTYPE, JTYPE, JRTYPE, NONE
   } itype_e;

   // Last six are branch compares, they drive taken only
   typedef enum logic [4:0] {
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B,
      EQ, NE, LT, GE, LTU, GEU
   } alu_op_e;

   typedef struct packed {
      itype_e   itype;
      alu_op_e  op;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      word_t    imm;
   } decode_t;

   typedef struct packed {
      logic ir_load;
      // Operand latches
      logic readin_a;
      logic readin_b;
      logic readin_pass;
      // Result register and register file write
      logic wd_q_readin;
      logic wd_q;
      logic mem_we;
      logic pc_load;
   } ctrl_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  we;
   } mem_req_t;

   typedef struct packed {
      logic     valid;
      word_t    pc;
      reg_idx_t rd;
      word_t    wdata;
   } retire_t;

endpackage

//--- control/control.sv
module control
   import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  stage_e stage_i,
   input  word_t  rdata_i,
   input  itype_e itype_i,
   output word_t  ir_o,
   output ctrl_t  ctrl_o
);

   word_t  ir_q;
   ctrl_t  ctrl_q;
   ctrl_t  ctrl_d;
   stage_e stage_nxt;

   // During FETCH the decoder already sees the new word
   assign ir_o = ctrl_q.ir_load ? rdata_i : ir_q;

   always_ff @(posedge clk) begin
      if (ctrl_q.ir_load) begin
         ir_q <= rdata_i;
      end
   end

   // Strobes are registered one stage ahead
   assign stage_nxt = (stage_i == WRITEBACK) ? FETCH : stage_e'(stage_i + 3'd1);

   always_comb begin
      ctrl_d = '0;
      case (stage_nxt)
         FETCH: begin
            ctrl_d.ir_load = 1'b1;
         end
         DECODE: begin
            case (itype_i)
               RTYPE, ITYPE, LTYPE, UPCTYPE: begin
                  ctrl_d.readin_a = 1'b1;
                  ctrl_d.readin_b = 1'b1;
               end
               STYPE, BTYPE: begin
                  ctrl_d.readin_a    = 1'b1;
                  ctrl_d.readin_b    = 1'b1;
                  ctrl_d.readin_pass = 1'b1;
               end
               UTYPE, JRTYPE: begin
                  ctrl_d.readin_a = 1'b1;
               end
               default: begin
               end
            endcase
         end
         EXECUTE: begin
            ctrl_d.wd_q_readin = itype_i inside {RTYPE, ITYPE, UPCTYPE, STYPE, LTYPE};
         end
         MEMORY: begin
            ctrl_d.mem_we      = (itype_i == STYPE);
            // Load data goes into the result register
            ctrl_d.wd_q_readin = (itype_i == LTYPE);
         end
         WRITEBACK: begin
            ctrl_d.pc_load = 1'b1;
            ctrl_d.wd_q    = itype_i inside {RTYPE, ITYPE, UTYPE, UPCTYPE, LTYPE,
                                             JTYPE, JRTYPE};
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         ctrl_q         <= '0;
         // First cycle out of reset is FETCH
         ctrl_q.ir_load <= 1'b1;
      end else begin
         ctrl_q <= ctrl_d;
      end
   end

   assign ctrl_o = ctrl_q;

   a_no_we_on_fetch: assert property (
      @(posedge clk) disable iff (!reset)
      !(ctrl_q.mem_we && ctrl_q.ir_load)
   );

   a_pc_load_in_wb: assert property (
      @(posedge clk) disable iff (!reset)
      ctrl_q.pc_load |-> (stage_i == WRITEBACK)
   );

endmodule

//--- control/stage_counter.sv
`include "cpu_config.svh"

module stage_counter
   import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   output stage_e stage_o
);

   logic [2:0] cnt;

   always_ff @(posedge clk) begin
      if (!reset) begin
         cnt <= 3'(FETCH);
      end else if (cnt == 3'(`CPU_STAGES - 1)) begin
         cnt <= 3'(FETCH);
      end else begin
         cnt <= cnt + 3'd1;
      end
   end

   assign stage_o = stage_e'(cnt);

   // Counter width leaves three codes unused
   a_stage_legal: assert property (
      @(posedge clk) disable iff (!reset)
      stage_o inside {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK}
   );

endmodule

//--- filelist.f
+incdir+common
common/cpu_pkg.sv
control/stage_counter.sv
control/control.sv
logic/decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/datapath.sv
logic/cpu_top.sv
tests/tb_cpu.sv

//--- logic/alu.sv
module alu
   import cpu_pkg::*;
(
   input  alu_op_e op_i,
   input  word_t   a_i,
   input  word_t   b_i,
   output word_t   result_o,
   output logic    taken_o
);

   logic       lt_s;
   logic       lt_u;
   logic       eq;
   logic [4:0] shamt;

   assign lt_s  = $signed(a_i) < $signed(b_i);
   assign lt_u  = a_i < b_i;
   assign eq    = (a_i == b_i);
   assign shamt = b_i[4:0];

   always_comb begin
      case (op_i)
         ADD:     result_o = a_i + b_i;
         SUB:     result_o = a_i - b_i;
         SLL:     result_o = a_i << shamt;
         SLT:     result_o = {31'd0, lt_s};
         SLTU:    result_o = {31'd0, lt_u};
         XOR:     result_o = a_i ^ b_i;
         SRL:     result_o = a_i >> shamt;
         SRA:     result_o = word_t'($signed(a_i) >>> shamt);
         OR:      result_o = a_i | b_i;
         AND:     result_o = a_i & b_i;
         PASS_B:  result_o = b_i;
         default: result_o = '0;
      endcase
   end

   // Branch compares
   always_comb begin
      case (op_i)
         EQ:      taken_o = eq;
         NE:      taken_o = !eq;
         LT:      taken_o = lt_s;
         GE:      taken_o = !lt_s;
         LTU:     taken_o = lt_u;
         GEU:     taken_o = !lt_u;
         default: taken_o = 1'b0;
      endcase
   end

endmodule

//--- logic/cpu_top.sv
module cpu_top
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  word_t    rdata_i,
   output mem_req_t mem_o,
   output retire_t  retire_o
);

   stage_e  stage;
   word_t   ir;
   ctrl_t   ctrl;
   decode_t dec;

   stage_counter i_stage_counter (
      .clk     (clk),
      .reset   (reset),
      .stage_o (stage)
   );

   control i_control (
      .clk     (clk),
      .reset   (reset),
      .stage_i (stage),
      .rdata_i (rdata_i),
      .itype_i (dec.itype),
      .ir_o    (ir),
      .ctrl_o  (ctrl)
   );

   decoder i_decoder (
      .ir_i  (ir),
      .dec_o (dec)
   );

   datapath i_datapath (
      .clk      (clk),
      .reset    (reset),
      .ctrl_i   (ctrl),
      .dec_i    (dec),
      .stage_i  (stage),
      .rdata_i  (rdata_i),
      .mem_o    (mem_o),
      .retire_o (retire_o)
   );

endmodule

//--- logic/datapath.sv
`include "cpu_config.svh"

module datapath
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  ctrl_t    ctrl_i,
   input  decode_t  dec_i,
   input  stage_e   stage_i,
   input  word_t    rdata_i,
   output mem_req_t mem_o,
   output retire_t  retire_o
);

   word_t pc_q;
   word_t a_q;
   word_t b_q;
   word_t pass_q;
   word_t res_q;
   word_t rs1_data;
   word_t rs2_data;
   word_t alu_b;
   word_t alu_res;
   logic  taken;
   word_t pc_plus4;
   word_t jump_base;
   word_t jump_target;
   word_t pc_next;
   word_t wb_data;

   reg_file i_reg_file (
      .clk      (clk),
      .reset    (reset),
      .rs1_i    (dec_i.rs1),
      .rs2_i    (dec_i.rs2),
      .rd_i     (dec_i.rd),
      .we_i     (ctrl_i.wd_q),
      .wdata_i  (wb_data),
      .rdata1_o (rs1_data),
      .rdata2_o (rs2_data)
   );

   // Branches compare rs1 against the pass latch
   assign alu_b = (dec_i.itype == BTYPE) ? pass_q : b_q;

   alu i_alu (
      .op_i     (dec_i.op),
      .a_i      (a_q),
      .b_i      (alu_b),
      .result_o (alu_res),
      .taken_o  (taken)
   );

   always_ff @(posedge clk) begin
      if (ctrl_i.readin_a) begin
         a_q <= (dec_i.itype == UPCTYPE) ? pc_q : rs1_data;
      end
      if (ctrl_i.readin_b) begin
         b_q <= (dec_i.itype == RTYPE) ? rs2_data : dec_i.imm;
      end
      if (ctrl_i.readin_pass) begin
         pass_q <= rs2_data;
      end
      if (ctrl_i.wd_q_readin) begin
         res_q <= (stage_i == MEMORY) ? rdata_i : alu_res;
      end
   end

   assign pc_plus4    = pc_q + 32'd4;
   assign jump_base   = (dec_i.itype == JRTYPE) ? a_q : pc_q;
   assign jump_target = (jump_base + dec_i.imm) & ~32'd1;

   always_comb begin
      case (dec_i.itype)
         JTYPE, JRTYPE: pc_next = jump_target;
         BTYPE:         pc_next = taken ? jump_target : pc_plus4;
         default:       pc_next = pc_plus4;
      endcase
      case (dec_i.itype)
         JTYPE, JRTYPE: wb_data = pc_plus4;
         UTYPE:         wb_data = dec_i.imm;
         default:       wb_data = res_q;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         pc_q <= `CPU_RESET_PC;
      end else if (ctrl_i.pc_load) begin
         pc_q <= pc_next;
      end
   end

   assign mem_o.addr  = (stage_i == MEMORY) ? res_q : pc_q;
   assign mem_o.wdata = pass_q;
   assign mem_o.we    = ctrl_i.mem_we;

   // Every instruction retires on its PC update
   assign retire_o.valid = ctrl_i.pc_load;
   assign retire_o.pc    = pc_q;
   assign retire_o.rd    = ctrl_i.wd_q ? dec_i.rd : '0;
   assign retire_o.wdata = (ctrl_i.wd_q && dec_i.rd != '0) ? wb_data : '0;

endmodule

//--- logic/decoder.sv
module decoder
   import cpu_pkg::*;
(
   input  word_t   ir_i,
   output decode_t dec_o
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       alt;
   word_t      imm_i;
   word_t      imm_s;
   word_t      imm_b;
   word_t      imm_u;
   word_t      imm_j;
   alu_op_e    arith_op;

   assign opcode = ir_i[6:0];
   assign funct3 = ir_i[14:12];
   assign alt    = ir_i[30];

   assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
   assign imm_s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
   assign imm_b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
   assign imm_u = {ir_i[31:12], 12'd0};
   assign imm_j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

   // Shared by OP and OP-IMM
   always_comb begin
      case (funct3)
         3'b000:  arith_op = ADD;
         3'b001:  arith_op = SLL;
         3'b010:  arith_op = SLT;
         3'b011:  arith_op = SLTU;
         3'b100:  arith_op = XOR;
         3'b101:  arith_op = alt ? SRA : SRL;
         3'b110:  arith_op = OR;
         default: arith_op = AND;
      endcase
   end

   always_comb begin
      dec_o.rd    = ir_i[11:7];
      dec_o.rs1   = ir_i[19:15];
      dec_o.rs2   = ir_i[24:20];
      dec_o.itype = NONE;
      dec_o.op    = ADD;
      dec_o.imm   = '0;
      case (opcode)
         7'b0110011: begin
            dec_o.itype = RTYPE;
            dec_o.op    = (funct3 == 3'b000 && alt) ? SUB : arith_op;
         end
         7'b0010011: begin
            dec_o.itype = ITYPE;
            dec_o.op    = arith_op;
            dec_o.imm   = imm_i;
         end
         7'b0100011: begin
            dec_o.itype = STYPE;
            dec_o.imm   = imm_s;
         end
         7'b1100011: begin
            dec_o.itype = BTYPE;
            dec_o.imm   = imm_b;
            case (funct3)
               3'b001:  dec_o.op = NE;
               3'b100:  dec_o.op = LT;
               3'b101:  dec_o.op = GE;
               3'b110:  dec_o.op = LTU;
               3'b111:  dec_o.op = GEU;
               default: dec_o.op = EQ;
            endcase
         end
         7'b0110111: begin
            dec_o.itype = UTYPE;
            dec_o.op    = PASS_B;
            dec_o.imm   = imm_u;
         end
         7'b0010111: begin
            dec_o.itype = UPCTYPE;
            dec_o.imm   = imm_u;
         end
         7'b0000011: begin
            dec_o.itype = LTYPE;
            dec_o.imm   = imm_i;
         end
         7'b1101111: begin
            dec_o.itype = JTYPE;
            dec_o.imm   = imm_j;
         end
         7'b1100111: begin
            dec_o.itype = JRTYPE;
            dec_o.imm   = imm_i;
         end
         default: begin
         end
      endcase
   end

endmodule

//--- logic/reg_file.sv
`include "cpu_config.svh"

module reg_file
   import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  reg_idx_t rs1_i,
   input  reg_idx_t rs2_i,
   input  reg_idx_t rd_i,
   input  logic     we_i,
   input  word_t    wdata_i,
   output word_t    rdata1_o,
   output word_t    rdata2_o
);

   // x0 cleared by reset and never written
   word_t regs [`CPU_NREGS];

   always_ff @(posedge clk) begin
      if (!reset) begin
         regs[0] <= '0;
      end else if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   assign rdata1_o = regs[rs1_i];
   assign rdata2_o = regs[rs2_i];

   a_x0_stays_zero: assert property (
      @(posedge clk) disable iff (!reset)
      (we_i && rd_i == '0) |=>
         (rs1_i != '0 || rdata1_o == '0) && (rs2_i != '0 || rdata2_o == '0)
   );

endmodule

//--- tests/tb_cpu.sv
`include "cpu_config.svh"

module tb_cpu
   import cpu_pkg::*;
();

   localparam int max_rows = 64;
   localparam logic [6:0] op_reg    = 7'b0110011;
   localparam logic [6:0] op_imm    = 7'b0010011;
   localparam logic [6:0] op_load   = 7'b0000011;
   localparam logic [6:0] op_store  = 7'b0100011;
   localparam logic [6:0] op_branch = 7'b1100011;
   localparam logic [6:0] op_lui    = 7'b0110111;
   localparam logic [6:0] op_auipc  = 7'b0010111;
   localparam logic [6:0] op_jal    = 7'b1101111;
   localparam logic [6:0] op_jalr   = 7'b1100111;

   logic     clk = 1'b0;
   logic     reset;
   word_t    rdata;
   mem_req_t mem_req;
   retire_t  retire;

   word_t    ram [256];
   word_t    xr [32];
   word_t    pc_b;
   int       n_rows = 0;
   int       cycles = 0;
   int       cycle_limit = 1000;
   int       mismatches = 0;
   int       failures = 0;

   // Expected retire sequence
   word_t    row_pc [max_rows];
   reg_idx_t row_rd [max_rows];
   word_t    row_wdata [max_rows];
   logic     row_store [max_rows];
   word_t    row_addr [max_rows];
   word_t    row_data [max_rows];

   cpu_top i_dut (
      .clk      (clk),
      .reset    (reset),
      .rdata_i  (rdata),
      .mem_o    (mem_req),
      .retire_o (retire)
   );

   always #4 clk = ~clk;

   // Combinational read, write on the clock edge
   assign rdata = ram[mem_req.addr[9:2]];

   always @(posedge clk) begin
      if (mem_req.we) begin
         ram[mem_req.addr[9:2]] = mem_req.wdata;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles, %0d retires expected", cycles, n_rows);
         $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic word_t sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd, input logic [6:0] op);
      return {f7, rs2, rs1, f3, rd, op};
   endfunction

   function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] op);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
   endfunction

   function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
   endfunction

   function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
   endfunction

   // RV32I OP and OP-IMM results
   function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   // Places one instruction and records what its retire must show
   task automatic add_row(input word_t instr, input reg_idx_t rd, input word_t value,
                          input word_t next_pc);
      ram[pc_b[9:2]]    = instr;
      row_pc[n_rows]    = pc_b;
      row_rd[n_rows]    = rd;
      row_wdata[n_rows] = (rd == 5'd0) ? 32'd0 : value;
      row_store[n_rows] = 1'b0;
      row_addr[n_rows]  = 32'd0;
      row_data[n_rows]  = 32'd0;
      if (rd != 5'd0) begin
         xr[rd] = value;
      end
      n_rows++;
      pc_b = next_pc;
   endtask

   task automatic build_program();
      word_t      rnd;
      word_t      imm;
      word_t      v;
      logic [2:0] f3;
      logic       alt;
      logic       taken;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      pc_b = `CPU_RESET_PC;
      rnd  = $urandom;
      add_row(enc_i(rnd[11:0], 5'd0, 3'd0, 5'd1, op_imm), 5'd1, sext12(rnd[11:0]), pc_b + 4);
      rnd = $urandom;
      if (sext12(rnd[11:0]) == xr[1]) begin
         rnd = rnd ^ 32'd1;
      end
      add_row(enc_i(rnd[11:0], 5'd0, 3'd0, 5'd2, op_imm), 5'd2, sext12(rnd[11:0]), pc_b + 4);
      // Register-register, SUB and SRA last
      for (int k = 0; k < 10; k++) begin
         f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
         alt = (k >= 8);
         add_row(enc_r({1'b0, alt, 5'd0}, 5'd2, 5'd1, f3, 5'(3 + k), op_reg), 5'(3 + k),
                 alu_ref(f3, alt, xr[1], xr[2]), pc_b + 4);
      end
      for (int k = 0; k < 9; k++) begin
         f3  = (k < 8) ? 3'(k) : 3'd5;
         alt = (k == 8);
         rnd = $urandom;
         if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {20'd0, 1'b0, alt, 5'd0, rnd[4:0]};
         end else begin
            imm = sext12(rnd[11:0]);
         end
         add_row(enc_i(imm[11:0], 5'd1, f3, 5'(20 + k), op_imm), 5'(20 + k),
                 alu_ref(f3, alt, xr[1], imm), pc_b + 4);
      end
      rnd = $urandom;
      add_row({rnd[31:12], 5'd13, op_lui}, 5'd13, {rnd[31:12], 12'd0}, pc_b + 4);
      rnd = $urandom;
      add_row({rnd[31:12], 5'd14, op_auipc}, 5'd14, pc_b + {rnd[31:12], 12'd0}, pc_b + 4);
      // x0 ignores the write, then reads back as zero
      add_row(enc_i(12'd5, 5'd1, 3'd0, 5'd0, op_imm), 5'd0, 32'd0, pc_b + 4);
      add_row(enc_r(7'd0, 5'd2, 5'd0, 3'd6, 5'd15, op_reg), 5'd15, xr[2], pc_b + 4);
      add_row(enc_i(12'h200, 5'd0, 3'd0, 5'd16, op_imm), 5'd16, 32'h200, pc_b + 4);
      add_row(enc_s(12'd4, 5'd3, 5'd16), 5'd0, 32'd0, pc_b + 4);
      row_store[n_rows - 1] = 1'b1;
      row_addr[n_rows - 1]  = xr[16] + 32'd4;
      row_data[n_rows - 1]  = xr[3];
      add_row(enc_i(12'd4, 5'd16, 3'd2, 5'd17, op_load), 5'd17, xr[3], pc_b + 4);
      // Each compare kind with (x1,x2), (x2,x1) and (x1,x1)
      for (int k = 0; k < 18; k++) begin
         f3    = (k / 3 < 2) ? 3'(k / 3) : 3'(k / 3 + 2);
         rs1   = (k % 3 == 1) ? 5'd2 : 5'd1;
         rs2   = (k % 3 == 0) ? 5'd2 : 5'd1;
         taken = branch_ref(f3, xr[rs1], xr[rs2]);
         add_row(enc_b(13'd8, rs2, rs1, f3), 5'd0, 32'd0, taken ? pc_b + 8 : pc_b + 4);
      end
      add_row(enc_j(21'd12, 5'd18), 5'd18, pc_b + 4, pc_b + 12);
      // Odd sum so that the cleared bit 0 matters
      v = pc_b + 32'd16;
      add_row(enc_i(v[11:0], 5'd0, 3'd0, 5'd19, op_imm), 5'd19, v, pc_b + 4);
      add_row(enc_i(12'd1, 5'd19, 3'd0, 5'd29, op_jalr), 5'd29, pc_b + 4,
              (xr[19] + 32'd1) & ~32'd1);
      add_row({20'd0, 5'd3, 7'b0001011}, 5'd0, 32'd0, pc_b + 4);
      add_row(enc_r(7'd0, 5'd0, 5'd3, 3'd6, 5'd30, op_reg), 5'd30, xr[3], pc_b + 4);
   endtask

   task automatic report_mismatch(input string what, input int row, input word_t got,
                                  input word_t exp);
      mismatches++;
      $display("mismatch at time %0t: row %0d %s is %h, expected %h",
               $time, row, what, got, exp);
   endtask

   // Waits for the next retire and checks it together with any memory write
   task automatic check_row(input int i);
      int n;
      int we_cnt;
      int exp_we;
      n      = 0;
      we_cnt = 0;
      exp_we = row_store[i] ? 1 : 0;
      do begin
         @(negedge clk);
         n++;
         if (mem_req.we) begin
            we_cnt++;
            if (row_store[i] && mem_req.addr != row_addr[i]) begin
               report_mismatch("store address", i, mem_req.addr, row_addr[i]);
            end
            if (row_store[i] && mem_req.wdata != row_data[i]) begin
               report_mismatch("store data", i, mem_req.wdata, row_data[i]);
            end
         end
      end while (!retire.valid && n < 5);
      if (!retire.valid) begin
         failures++;
         $display("row %0d did not retire within 5 cycles", i);
      end else begin
         if (n != 5) begin
            report_mismatch("cycles to retire", i, n, 32'd5);
         end
         if (retire.pc != row_pc[i]) begin
            report_mismatch("pc", i, retire.pc, row_pc[i]);
         end
         if (retire.rd != row_rd[i]) begin
            report_mismatch("rd", i, 32'(retire.rd), 32'(row_rd[i]));
         end
         if (retire.wdata != row_wdata[i]) begin
            report_mismatch("wdata", i, retire.wdata, row_wdata[i]);
         end
      end
      if (we_cnt != exp_we) begin
         report_mismatch("memory write cycles", i, we_cnt, exp_we);
      end
   endtask

   initial begin
      reset = 1'b0;
      void'($urandom(32'h55a1));
      for (int i = 0; i < 256; i++) begin
         ram[i] = (i << 7) | 32'h0000_000b;
      end
      build_program();
      cycle_limit = n_rows * 5 + 20;
      repeat (2) @(posedge clk);
      #1 reset = 1'b1;
      for (int i = 0; i < n_rows; i++) begin
         check_row(i);
      end
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
